// ==== weightedBus_defines.svh ====
`ifndef WEIGHTED_BUS_DEFINES_SVH
`define WEIGHTED_BUS_DEFINES_SVH

// bus geometry
`define NUM_MASTERS 4
`define NUM_TARGETS 4
`define ADDR_W      20
`define DATA_W      16
`define COUNT_W     9

// transfers per window for each master, index 0 highest priority
`define QUOTA_M0 105
`define QUOTA_M1 105
`define QUOTA_M2 96
`define QUOTA_M3 30

// completed transfers before every count clears
`define WINDOW_XFERS 501

// inclusive target windows
`define TARGET0_LO 20'hf8ddc
`define TARGET0_HI 20'hf8edc
`define TARGET1_LO 20'hf7015
`define TARGET1_HI 20'hf7085
`define TARGET2_LO 20'hf58ce
`define TARGET2_HI 20'hf58df
`define TARGET3_LO 20'hf3ca5
`define TARGET3_HI 20'hf3d61

`endif

// ==== weightedBusPkg.sv ====
`include "weightedBus_defines.svh"

package weightedBusPkg;

  // one bit per master: need, grant, unsat
  typedef logic [`NUM_MASTERS-1:0] masterVecT;

  // one bit per target
  typedef logic [`NUM_TARGETS-1:0] targetVecT;

  // bus address
  typedef logic [`ADDR_W-1:0] addrT;

  // data word, both directions
  typedef logic [`DATA_W-1:0] dataT;

  // transfer counts, wide enough for a full window
  typedef logic [`COUNT_W-1:0] countT;

endpackage

// ==== xferIf.sv ====
`timescale 1ns/1ns

// the transfer currently granted, from arbiter to router
interface xferIf;

  weightedBusPkg::masterVecT grant;    // one-hot owner, zero when idle
  weightedBusPkg::addrT      busAddr;  // owner's address
  weightedBusPkg::dataT      busWdata; // owner's write data
  logic                      xferDone; // single-cycle end of transfer

  modport arbiter (
    output grant,
    output busAddr,
    output busWdata,
    input  xferDone
  );

  modport router (
    input  grant,
    input  busAddr,
    input  busWdata,
    output xferDone
  );

endinterface

// ==== quotaTracker.sv ====
`timescale 1ns/1ns
`include "weightedBus_defines.svh"

module quotaTracker (
  input  logic                      sysClk,
  input  logic                      rstN,
  input  weightedBusPkg::masterVecT grant,
  input  logic                      xferDone,
  output weightedBusPkg::masterVecT unsat,
  output logic                      windowClear
);

  localparam weightedBusPkg::countT quotaTab [`NUM_MASTERS] = '{
    `QUOTA_M0,
    `QUOTA_M1,
    `QUOTA_M2,
    `QUOTA_M3
  };
  localparam weightedBusPkg::countT windowLen = `WINDOW_XFERS;
  localparam weightedBusPkg::countT countOne = 1;

  weightedBusPkg::countT xferCount [`NUM_MASTERS]; // per master, this window
  weightedBusPkg::countT totalCount;               // all masters, this window

  assign windowClear = (totalCount == windowLen);

  // below quota means still owed transfers this window
  always_comb begin
    for (int i = 0; i < `NUM_MASTERS; i++) begin
      unsat[i] = (xferCount[i] < quotaTab[i]);
    end
  end

  always_ff @(posedge sysClk or negedge rstN) begin
    if (!rstN) begin
      totalCount <= '0;
      for (int i = 0; i < `NUM_MASTERS; i++) begin
        xferCount[i] <= '0;
      end
    end else if (windowClear) begin
      // new window, every master starts over
      totalCount <= '0;
      for (int i = 0; i < `NUM_MASTERS; i++) begin
        xferCount[i] <= '0;
      end
    end else if (xferDone) begin
      totalCount <= totalCount + countOne;
      for (int i = 0; i < `NUM_MASTERS; i++) begin
        if (grant[i]) begin
          xferCount[i] <= xferCount[i] + countOne; // owner of the ending transfer
        end
      end
    end
  end

endmodule

// ==== grantSelector.sv ====
`timescale 1ns/1ns
`include "weightedBus_defines.svh"

module grantSelector (
  input  logic                      sysClk,
  input  logic                      rstN,
  input  weightedBusPkg::masterVecT need,
  input  weightedBusPkg::addrT      mAddr [`NUM_MASTERS],
  input  weightedBusPkg::dataT      mWdata [`NUM_MASTERS],
  input  weightedBusPkg::masterVecT unsat,
  input  logic                      windowClear,
  xferIf.arbiter                    bus
);

  weightedBusPkg::masterVecT grantQ;
  weightedBusPkg::masterVecT nextGrant;
  logic                      idle;

  // lowest index wins, masters still under quota go first
  function automatic weightedBusPkg::masterVecT pickGrant(
    input weightedBusPkg::masterVecT req,
    input weightedBusPkg::masterVecT owed
  );
    weightedBusPkg::masterVecT pref;
    weightedBusPkg::masterVecT pick;
    pref = req & owed;
    pick = '0;
    if (pref != '0) begin
      pick = pref & (~pref + 1'b1); // isolate lowest set bit
    end else begin
      pick = req & (~req + 1'b1);   // everyone satisfied, plain priority
    end
    return pick;
  endfunction

  assign idle      = (grantQ == '0);
  assign nextGrant = pickGrant(need, unsat);
  assign bus.grant = grantQ;

  always_ff @(posedge sysClk or negedge rstN) begin
    if (!rstN) begin
      grantQ <= '0;
    end else if (bus.xferDone) begin
      grantQ <= '0;
    end else if (idle && !windowClear) begin
      grantQ <= nextGrant; // stays zero if nobody asks
    end
  end

  // route the owner's address and data onto the bus
  always_comb begin
    bus.busAddr  = '0;
    bus.busWdata = '0;
    for (int i = 0; i < `NUM_MASTERS; i++) begin
      if (grantQ[i]) begin
        bus.busAddr  = mAddr[i];
        bus.busWdata = mWdata[i];
      end
    end
  end

endmodule

// ==== targetRouter.sv ====
`timescale 1ns/1ns
`include "weightedBus_defines.svh"

module targetRouter (
  input  logic                      sysClk,
  input  logic                      rstN,
  xferIf.router                     bus,
  output weightedBusPkg::targetVecT tarActive,
  output weightedBusPkg::addrT      tarAdr,
  output weightedBusPkg::dataT      tarWdata,
  input  weightedBusPkg::dataT      tarRdata [`NUM_TARGETS],
  input  weightedBusPkg::targetVecT tarLast,
  output weightedBusPkg::dataT      mRdata
);

  localparam weightedBusPkg::addrT loLim [`NUM_TARGETS] = '{
    `TARGET0_LO,
    `TARGET1_LO,
    `TARGET2_LO,
    `TARGET3_LO
  };
  localparam weightedBusPkg::addrT hiLim [`NUM_TARGETS] = '{
    `TARGET0_HI,
    `TARGET1_HI,
    `TARGET2_HI,
    `TARGET3_HI
  };

  weightedBusPkg::targetVecT hit;     // decode of the granted address
  weightedBusPkg::dataT      rdSel;   // read data of the active target
  logic                      missPend; // launched transfer hit no window
  logic                      inFlight;
  logic                      launch;
  logic                      hitDone;

  always_comb begin
    for (int t = 0; t < `NUM_TARGETS; t++) begin
      hit[t] = (bus.busAddr >= loLim[t]) && (bus.busAddr <= hiLim[t]);
    end
  end

  always_comb begin
    rdSel = '0;
    for (int t = 0; t < `NUM_TARGETS; t++) begin
      if (tarActive[t]) begin
        rdSel = tarRdata[t];
      end
    end
  end

  assign inFlight     = (tarActive != '0) || missPend;
  assign launch       = (bus.grant != '0) && !inFlight; // first cycle of a grant
  assign hitDone      = ((tarActive & tarLast) != '0);  // only the active target ends it
  assign bus.xferDone = hitDone || missPend;

  always_ff @(posedge sysClk or negedge rstN) begin
    if (!rstN) begin
      tarActive <= '0;
      missPend  <= 1'b0;
      mRdata    <= '0;
    end else if (bus.xferDone) begin
      tarActive <= '0;
      missPend  <= 1'b0;
      mRdata    <= missPend ? '0 : rdSel; // a miss reads as zero
    end else if (launch) begin
      tarActive <= hit;
      missPend  <= (hit == '0);
    end
  end

  // address and write data held for the whole transfer
  always_ff @(posedge sysClk) begin
    if (launch) begin
      tarAdr   <= bus.busAddr;
      tarWdata <= bus.busWdata;
    end
  end

endmodule

// ==== weightedBus.sv ====
`timescale 1ns/1ns
`include "weightedBus_defines.svh"

module weightedBus (
  input  logic                      sysClk,
  input  logic                      rstN,
  // masters
  input  weightedBusPkg::masterVecT need,
  output weightedBusPkg::masterVecT grant,
  input  weightedBusPkg::addrT      mAddr [`NUM_MASTERS],
  input  weightedBusPkg::dataT      mWdata [`NUM_MASTERS],
  output weightedBusPkg::dataT      mRdata, // valid for the master just released
  // targets
  output weightedBusPkg::targetVecT tarActive,
  output weightedBusPkg::addrT      tarAdr,
  output weightedBusPkg::dataT      tarWdata,
  input  weightedBusPkg::dataT      tarRdata [`NUM_TARGETS],
  input  weightedBusPkg::targetVecT tarLast
);

  weightedBusPkg::masterVecT unsat;
  logic                      windowClear;

  xferIf bus ();

  assign grant = bus.grant;

  quotaTracker i_quotaTracker (
    .sysClk      (sysClk),
    .rstN        (rstN),
    .grant       (bus.grant),
    .xferDone    (bus.xferDone),
    .unsat       (unsat),
    .windowClear (windowClear)
  );

  grantSelector i_grantSelector (
    .sysClk      (sysClk),
    .rstN        (rstN),
    .need        (need),
    .mAddr       (mAddr),
    .mWdata      (mWdata),
    .unsat       (unsat),
    .windowClear (windowClear),
    .bus         (bus.arbiter)
  );

  targetRouter i_targetRouter (
    .sysClk    (sysClk),
    .rstN      (rstN),
    .bus       (bus.router),
    .tarActive (tarActive),
    .tarAdr    (tarAdr),
    .tarWdata  (tarWdata),
    .tarRdata  (tarRdata),
    .tarLast   (tarLast),
    .mRdata    (mRdata)
  );

endmodule

// ==== tbMonitor.sv ====
`timescale 1ns/1ns
`include "weightedBus_defines.svh"

module tbMonitor (
  input  logic                      sysClk,
  input  logic                      rstN,
  input  logic [127:0]              testName,
  input  weightedBusPkg::masterVecT need,
  input  weightedBusPkg::masterVecT grant,
  input  weightedBusPkg::addrT      mAddr [`NUM_MASTERS],
  input  weightedBusPkg::dataT      mWdata [`NUM_MASTERS],
  input  weightedBusPkg::dataT      mRdata,
  input  weightedBusPkg::targetVecT tarActive,
  input  weightedBusPkg::addrT      tarAdr,
  input  weightedBusPkg::dataT      tarWdata,
  output int                        mismatchCount,
  output int                        otherCount
);

  localparam int quota [`NUM_MASTERS] = '{`QUOTA_M0, `QUOTA_M1, `QUOTA_M2, `QUOTA_M3};
  localparam logic [15:0] rdMask [`NUM_TARGETS] = '{16'h1000, 16'h2200, 16'h3330, 16'h4444};

  int cnt [`NUM_MASTERS]; // mirrored per-master counts
  int total;
  int owner;
  logic clearPend;
  logic launchPend;
  weightedBusPkg::masterVecT prevGrant;
  weightedBusPkg::masterVecT prevNeed;
  weightedBusPkg::masterVecT expGrant;
  weightedBusPkg::targetVecT expAct;
  weightedBusPkg::addrT      ownerAddr;
  weightedBusPkg::dataT      ownerData;
  weightedBusPkg::dataT      expRd;

  // expected grant from requests and the mirrored counts
  function automatic weightedBusPkg::masterVecT refGrant(input weightedBusPkg::masterVecT req);
    weightedBusPkg::masterVecT res;
    res = '0;
    if (total != `WINDOW_XFERS) begin
      for (int i = `NUM_MASTERS - 1; i >= 0; i--) begin
        if (req[i]) res = weightedBusPkg::masterVecT'(1 << i);
      end
      for (int i = `NUM_MASTERS - 1; i >= 0; i--) begin
        if (req[i] && cnt[i] < quota[i]) res = weightedBusPkg::masterVecT'(1 << i);
      end
    end
    return res;
  endfunction

  function automatic weightedBusPkg::targetVecT decode(input weightedBusPkg::addrT a);
    decode = '0;
    decode[0] = (a >= `TARGET0_LO) && (a <= `TARGET0_HI);
    decode[1] = (a >= `TARGET1_LO) && (a <= `TARGET1_HI);
    decode[2] = (a >= `TARGET2_LO) && (a <= `TARGET2_HI);
    decode[3] = (a >= `TARGET3_LO) && (a <= `TARGET3_HI);
  endfunction

  task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    mismatchCount++;
    $display("mismatch %0s %0s: expected %0h, actual %0h", testName, what, exp, act);
  endtask

  task automatic failure(input string what);
    otherCount++;
    $display("error in %0s: %0s", testName, what);
  endtask

  initial begin
    mismatchCount = 0;
    otherCount = 0;
  end

  // sample mid-cycle, everything is settled there
  always @(negedge sysClk) begin
    if (!rstN) begin
      if (grant != '0 || tarActive != '0 || mRdata != '0) failure("outputs not zero in reset");
      for (int i = 0; i < `NUM_MASTERS; i++) cnt[i] = 0;
      total = 0;
      clearPend = 1'b0;
      launchPend = 1'b0;
      prevGrant = '0;
      prevNeed = need;
      expRd = '0;
    end else begin
      if ($countones(grant) > 1) failure("more than one grant bit high");
      if ($countones(tarActive) > 1) failure("more than one target active");
      if (grant == '0 && tarActive != '0) failure("target active without a grant");
      if (prevGrant == '0) begin
        expGrant = refGrant(prevNeed); // decided at the edge just passed
        if (grant != expGrant) mismatch("grant", 32'(expGrant), 32'(grant));
      end
      if (launchPend) begin
        launchPend = 1'b0;
        expAct = decode(ownerAddr);
        if (tarActive != expAct) mismatch("tarActive", 32'(expAct), 32'(tarActive));
        expRd = '0; // miss reads zero
        for (int t = 0; t < `NUM_TARGETS; t++) begin
          if (expAct[t]) expRd = ownerAddr[15:0] ^ rdMask[t];
        end
        if (expAct != '0) begin
          if (tarAdr != ownerAddr) mismatch("tarAdr", 32'(ownerAddr), 32'(tarAdr));
          if (tarWdata != ownerData) mismatch("tarWdata", 32'(ownerData), 32'(tarWdata));
        end
      end
      if (prevGrant == '0 && grant != '0) begin
        launchPend = 1'b1;
        for (int i = 0; i < `NUM_MASTERS; i++) begin
          if (grant[i]) owner = i;
        end
        ownerAddr = mAddr[owner];
        ownerData = mWdata[owner];
      end
      if (clearPend) begin
        clearPend = 1'b0;
        total = 0;
        for (int i = 0; i < `NUM_MASTERS; i++) cnt[i] = 0;
      end else if (prevGrant != '0 && grant == '0) begin
        if (mRdata != expRd) mismatch("mRdata", 32'(expRd), 32'(mRdata));
        cnt[owner]++;
        total++;
        if (total == `WINDOW_XFERS) clearPend = 1'b1;
      end
      prevGrant = grant;
      prevNeed = need;
    end
  end

endmodule

// ==== tbWeightedBus.sv ====
`timescale 1ns/1ns
`include "weightedBus_defines.svh"

module tbWeightedBus;

  localparam int maxCycles = 20000; // ~700 transfers of up to 8 cycles, plus margin
  localparam logic [15:0] rdMask [`NUM_TARGETS] = '{16'h1000, 16'h2200, 16'h3330, 16'h4444};

  logic sysClk;
  logic rstN;
  logic [127:0] testName;
  weightedBusPkg::masterVecT need;
  weightedBusPkg::masterVecT grant;
  weightedBusPkg::addrT      mAddr [`NUM_MASTERS];
  weightedBusPkg::dataT      mWdata [`NUM_MASTERS];
  weightedBusPkg::dataT      mRdata;
  weightedBusPkg::targetVecT tarActive;
  weightedBusPkg::addrT      tarAdr;
  weightedBusPkg::dataT      tarWdata;
  weightedBusPkg::dataT      tarRdata [`NUM_TARGETS];
  weightedBusPkg::targetVecT tarLast;
  int mismatchCount;
  int otherCount;
  int cycles;
  int delayLeft [`NUM_TARGETS];
  logic busy [`NUM_TARGETS];

  weightedBus i_weightedBus (
    .sysClk(sysClk), .rstN(rstN), .need(need), .grant(grant), .mAddr(mAddr),
    .mWdata(mWdata), .mRdata(mRdata), .tarActive(tarActive), .tarAdr(tarAdr),
    .tarWdata(tarWdata), .tarRdata(tarRdata), .tarLast(tarLast)
  );

  tbMonitor i_tbMonitor (
    .sysClk(sysClk), .rstN(rstN), .testName(testName), .need(need), .grant(grant),
    .mAddr(mAddr), .mWdata(mWdata), .mRdata(mRdata), .tarActive(tarActive),
    .tarAdr(tarAdr), .tarWdata(tarWdata), .mismatchCount(mismatchCount),
    .otherCount(otherCount)
  );

  initial begin
    sysClk = 1'b0;
    forever #50 sysClk = ~sysClk;
  end

  // target models, read data from the address
  always_comb begin
    for (int t = 0; t < `NUM_TARGETS; t++) tarRdata[t] = tarAdr[15:0] ^ rdMask[t];
  end

  always @(posedge sysClk) begin
    #1;
    for (int t = 0; t < `NUM_TARGETS; t++) begin
      tarLast[t] = 1'b0;
      if (tarActive[t] && !busy[t]) begin
        busy[t] = 1'b1;
        delayLeft[t] = int'($urandom % 4) + 1;
      end
      if (busy[t]) begin
        delayLeft[t]--;
        if (delayLeft[t] == 0) begin
          tarLast[t] = 1'b1; // one cycle only
          busy[t] = 1'b0;
        end
      end
    end
  end

  task automatic singleXfer(input int m, input weightedBusPkg::addrT a,
                            input weightedBusPkg::dataT d);
    @(posedge sysClk);
    #1;
    need[m] = 1'b1;
    mAddr[m] = a;
    mWdata[m] = d;
    do begin
      @(posedge sysClk);
      #1;
    end while (!grant[m]);
    do begin
      @(posedge sysClk);
      #1;
    end while (grant[m]);
    need[m] = 1'b0;
  endtask

  // returns just after the n-th grant release
  task automatic countXfers(input int n);
    int seen;
    weightedBusPkg::masterVecT last;
    seen = 0;
    last = grant;
    while (seen < n) begin
      @(posedge sysClk);
      #1;
      if (last != '0 && grant == '0) seen++;
      last = grant;
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < maxCycles) begin
      @(posedge sysClk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", maxCycles);
    $display("errors: mismatch %0d, other %0d", mismatchCount, otherCount);
    $display("Regression failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h5352_e47c));
    testName = "reset";
    rstN = 1'b0;
    need = '0;
    tarLast = '0;
    for (int i = 0; i < `NUM_MASTERS; i++) begin
      mAddr[i] = '0;
      mWdata[i] = '0;
    end
    for (int t = 0; t < `NUM_TARGETS; t++) begin
      busy[t] = 1'b0;
      delayLeft[t] = 0;
    end
    repeat (16) @(posedge sysClk);
    #1;
    rstN = 1'b1;
    repeat (3) @(posedge sysClk);

    testName = "routing";
    singleXfer(2, `TARGET0_LO + 20'h3, 16'hc0de);
    singleXfer(2, `TARGET1_LO + 20'h11, 16'h1234);
    singleXfer(2, `TARGET2_HI, 16'hbeef);
    singleXfer(2, `TARGET3_LO + 20'h40, 16'h5a5a);

    testName = "miss";
    singleXfer(2, 20'h00100, 16'hdead);

    // all masters busy, each on its own window
    testName = "quota";
    @(posedge sysClk);
    #1;
    mAddr[0] = `TARGET0_LO + 20'h7;
    mAddr[1] = `TARGET1_LO + 20'h8;
    mAddr[2] = `TARGET2_LO + 20'h9;
    mAddr[3] = `TARGET3_LO + 20'ha;
    for (int i = 0; i < `NUM_MASTERS; i++) mWdata[i] = 16'h0100 + 16'(i);
    need = 4'b1111;
    countXfers(`WINDOW_XFERS - 5); // five done above

    testName = "window";
    need = 4'b1110;
    countXfers(110); // past master 1's fresh quota, master 2 takes over
    need = '0;
    repeat (5) @(posedge sysClk);

    $display("errors: mismatch %0d, other %0d", mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== weightedBus.f ====
+incdir+.
weightedBusPkg.sv
xferIf.sv
quotaTracker.sv
grantSelector.sv
targetRouter.sv
weightedBus.sv
tbMonitor.sv
tbWeightedBus.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator, then look for the pass line in the log
verilator --binary --timing -f weightedBus.f --top-module tbWeightedBus -o simv \
  > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 &&
grep -q "Regression passed" sim.log &&
echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }
